// ==== include/wb_cfg.svh ====
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// Bus geometry
`define WB_DATA_WIDTH 32                   // Data bus width in bits
`define WB_ADDR_WIDTH 32                   // Byte address width
`define WB_SEL_WIDTH  (`WB_DATA_WIDTH / 8) // One select per byte lane

// RAM slave
`define RAM_WORDS 256                      // Depth in data words

// Arbitration
`define ARB_PORTS_MAX         2            // Sizes the grant struct
`define ARB_ROUND_ROBIN       1            // 1 for round robin, 0 for fixed
`define ARB_LSB_HIGH_PRIORITY 0            // Fixed mode only, 0 lets MSB win

`endif

// ==== logic/wb_pkg.sv ====
`default_nettype none

`include "wb_cfg.svh"

package wb_pkg;

    // Master side of one Wishbone classic port
    typedef struct packed {
        logic [`WB_ADDR_WIDTH-1:0] adr;    // Byte address
        logic [`WB_DATA_WIDTH-1:0] dat;    // Write data
        logic                      we;     // High for write
        logic [`WB_SEL_WIDTH-1:0]  sel;    // Byte lane enables
        logic                      stb;    // Transfer strobe
        logic                      cyc;    // Bus cycle in progress
    } wb_req_t;

    // Slave return path
    typedef struct packed {
        logic [`WB_DATA_WIDTH-1:0] dat;    // Read data, valid with ack
        logic                      ack;    // One pulse per transfer
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/arb_pkg.sv ====
`default_nettype none

`include "wb_cfg.svh"

package arb_pkg;

    // Registered grant state, fixed at the widest supported arbiter
    typedef struct packed {
        logic [`ARB_PORTS_MAX-1:0]         grant;          // One-hot, zero when idle
        logic                              grant_valid;    // Some port owns the bus
        logic [$clog2(`ARB_PORTS_MAX)-1:0] grant_encoded;  // Index of last grant
    } arb_grant_t;

endpackage

`default_nettype wire

// ==== logic/arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module arbiter
    import arb_pkg::*;
#(
    parameter int PORTS             = 2,    // Active ports, up to ARB_PORTS_MAX
    parameter bit ROUND_ROBIN       = 1'b1, // Rotate priority after each grant
    parameter bit LSB_HIGH_PRIORITY = 1'b0  // Search direction / fixed winner
) (
    input  wire             clk,
    input  wire             reset_i,
    input  wire [PORTS-1:0] request_i,
    output arb_grant_t      grant_o
);

    localparam int PW = `ARB_PORTS_MAX;     // Struct width
    localparam int IW = $clog2(PW);         // Index width

    logic [PW-1:0] req_v;                   // Requests padded to struct width
    logic [PW-1:0] grant_v;                 // Decoded one-hot grant
    logic          valid_q;                 // Grant currently held
    logic [IW-1:0] enc_q;                   // Owner, or last owner when idle
    logic [IW-1:0] pick_idx;                // Winner of this cycle's search
    logic          pick_found;              // Any request present
    logic          held;                    // Owner still asserting request

    always_comb begin
        req_v                = '0;
        req_v[PORTS-1:0]     = request_i;   // Unused upper ports never request
    end

    // Blocking: owner keeps the bus until its own request drops
    assign held = valid_q && req_v[enc_q];

    // Priority search, order depends on mode
    always_comb begin : pick
        int p;
        p          = 0;
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = 1; i <= PORTS; i++) begin
            if (ROUND_ROBIN) begin
                if (LSB_HIGH_PRIORITY) begin
                    p = (int'(enc_q) + i) % PORTS;          // Upward from last owner
                end else begin
                    p = (int'(enc_q) + PORTS - i) % PORTS;  // Downward from last owner
                end
            end else begin
                if (LSB_HIGH_PRIORITY) begin
                    p = i - 1;                              // Port 0 first
                end else begin
                    p = PORTS - i;                          // Top port first
                end
            end
            if (!pick_found && req_v[p]) begin
                pick_found = 1'b1;                          // First hit wins
                pick_idx   = IW'(p);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            enc_q   <= IW'(PORTS - 1);      // Port 0 wins first tie
        end else if (!held) begin
            valid_q <= pick_found;          // Release and re-grant on one edge
            if (pick_found) begin
                enc_q <= pick_idx;          // Also the round-robin pointer
            end
        end
    end

    always_comb begin
        grant_v = '0;
        if (valid_q) begin
            grant_v[enc_q] = 1'b1;
        end
    end

    assign grant_o.grant         = grant_v;
    assign grant_o.grant_valid   = valid_q;
    assign grant_o.grant_encoded = enc_q;

    // Never two owners at once
    a_grant_onehot : assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(grant_v))
        else $error("arbiter grant not one-hot");

    // Owner requested on the edge that granted or kept it
    a_grant_backed : assert property (@(posedge clk) disable iff (reset_i)
        valid_q |-> |($past(req_v) & grant_v))
        else $error("arbiter grant without request");

endmodule

`default_nettype wire

// ==== logic/wb_arbiter_2.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_arbiter_2
    import wb_pkg::*;
    import arb_pkg::*;
(
    input  wire     clk,
    input  wire     reset_i,
    input  wire     wb_req_t m0_req_i,
    input  wire     wb_req_t m1_req_i,
    output wb_rsp_t m0_rsp_o,
    output wb_rsp_t m1_rsp_o,
    output wb_req_t s_req_o,
    input  wire     wb_rsp_t s_rsp_i
);

    logic [1:0] request_v;                  // One bit per master cyc
    arb_grant_t grant;                      // From the generic arbiter
    logic       m0_sel;                     // Master 0 owns the slave
    logic       m1_sel;                     // Master 1 owns the slave

    assign request_v = {m1_req_i.cyc, m0_req_i.cyc};

    arbiter #(
        .PORTS             (2),
        .ROUND_ROBIN       (1'(`ARB_ROUND_ROBIN)),
        .LSB_HIGH_PRIORITY (1'(`ARB_LSB_HIGH_PRIORITY))
    ) u_arbiter (
        .clk       (clk),
        .reset_i   (reset_i),
        .request_i (request_v),
        .grant_o   (grant)
    );

    assign m0_sel = grant.grant_valid & grant.grant[0];
    assign m1_sel = grant.grant_valid & grant.grant[1];

    // Slave side, zero when nobody owns the bus
    always_comb begin
        s_req_o = '0;
        if (grant.grant_valid) begin
            s_req_o = grant.grant_encoded ? m1_req_i : m0_req_i;
        end
        s_req_o.cyc = grant.grant_valid;    // Held through the release cycle
    end

    // Read data fans out, ack only to the owner
    always_comb begin
        m0_rsp_o.dat = s_rsp_i.dat;
        m0_rsp_o.ack = s_rsp_i.ack & m0_sel;
        m1_rsp_o.dat = s_rsp_i.dat;
        m1_rsp_o.ack = s_rsp_i.ack & m1_sel;
    end

    // Acked master owned the bus and was in a cycle when the RAM took its strobe
    a_m0_ack_owner : assert property (@(posedge clk) disable iff (reset_i)
        m0_rsp_o.ack |-> $past(m0_sel && m0_req_i.cyc))
        else $error("master 0 acked without grant");

    a_m1_ack_owner : assert property (@(posedge clk) disable iff (reset_i)
        m1_rsp_o.ack |-> $past(m1_sel && m1_req_i.cyc))
        else $error("master 1 acked without grant");

endmodule

`default_nettype wire

// ==== logic/wb_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_ram
    import wb_pkg::*;
(
    input  wire     clk,
    input  wire     reset_i,
    input  wire     wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    localparam int OFS  = $clog2(`WB_SEL_WIDTH);   // Byte offset bits
    localparam int IDXW = $clog2(`RAM_WORDS);      // Word index bits

    logic [`WB_DATA_WIDTH-1:0] mem [`RAM_WORDS];   // Powers up unknown
    logic [`WB_DATA_WIDTH-1:0] rd_q;               // Registered read word
    logic                      ack_q;              // One-cycle acknowledge
    logic [IDXW-1:0]           idx;                // Word address, wraps
    logic                      take;               // New strobe accepted

    assign idx  = req_i.adr[OFS +: IDXW];          // Upper address bits dropped

    // Ack low means this strobe has not been answered yet
    assign take = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;                 // Pulse, then a gap cycle
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (req_i.we) begin
                for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
                    if (req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];  // Lane write
                    end
                end
            end
            rd_q <= mem[idx];              // Full word, old value on writes
        end
    end

    assign rsp_o.dat = rd_q;
    assign rsp_o.ack = ack_q;

    // At most one transfer every two cycles
    a_ack_gap : assert property (@(posedge clk) disable iff (reset_i)
        ack_q |=> !ack_q)
        else $error("RAM ack high on consecutive cycles");

endmodule

`default_nettype wire

// ==== logic/wb_arb_ram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arb_ram_top
    import wb_pkg::*;
(
    input  wire     clk,
    input  wire     reset_i,
    input  wire     wb_req_t m0_req_i,
    input  wire     wb_req_t m1_req_i,
    output wb_rsp_t m0_rsp_o,
    output wb_rsp_t m1_rsp_o
);

    wb_req_t s_req;                         // Granted master toward RAM
    wb_rsp_t s_rsp;                         // RAM answer

    wb_arbiter_2 u_wb_arbiter_2 (
        .clk      (clk),
        .reset_i  (reset_i),
        .m0_req_i (m0_req_i),
        .m1_req_i (m1_req_i),
        .m0_rsp_o (m0_rsp_o),
        .m1_rsp_o (m1_rsp_o),
        .s_req_o  (s_req),
        .s_rsp_i  (s_rsp)
    );

    wb_ram u_wb_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (s_req),
        .rsp_o   (s_rsp)
    );

endmodule

`default_nettype wire

// ==== tests/tb_wb_arb_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module tb_wb_arb_ram
    import wb_pkg::*;
();

    typedef logic [0:0] mid_t;                  // Master index

    localparam int          WORDS          = `RAM_WORDS;
    localparam int          SELW           = `WB_SEL_WIDTH;
    localparam int          IDXW           = $clog2(WORDS);
    localparam int          RESET_CYCLES   = 4;
    localparam int          ACK_TIMEOUT    = 50;    // Cycles per ack wait
    localparam int          XFERS          = 400;   // Random transfers per master
    localparam int          IDLE_ACK_EDGES = 3;     // Ack in 2nd cycle after cyc, seen at 3rd edge
    localparam int unsigned SEED           = 32'h6e717c99;

    logic    clk = 1'b0;
    logic    reset_i;
    wb_req_t m_req [2];                         // Master models toward DUT
    wb_rsp_t m_rsp [2];

    logic [`WB_DATA_WIDTH-1:0] ref_mem [WORDS]; // Reference RAM contents
    logic                      written [WORDS]; // Word holds a known value
    mid_t    owner;                             // Master whose cycle is being acked
    logic    owner_valid = 1'b0;
    logic    prev_ack = 1'b0;                   // Any ack on the previous edge
    logic    reset_seen = 1'b0;                 // A reset edge has cleared the DUT

    always #5 clk = ~clk;

    wb_arb_ram_top DUT (
        .clk      (clk),
        .reset_i  (reset_i),
        .m0_req_i (m_req[0]),
        .m1_req_i (m_req[1]),
        .m0_rsp_o (m_rsp[0]),
        .m1_rsp_o (m_rsp[1])
    );

    task automatic stop_failed(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // Data is only meaningful when an ack is expected
    task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input string what);
        if (got.ack !== exp.ack || (exp.ack && got.dat !== exp.dat)) begin
            stop_failed($sformatf("CHECK FAILED at %0t: %s, got ack %b dat %h, expected ack %b dat %h",
                $time, what, got.ack, got.dat, exp.ack, exp.dat));
        end
    endtask

    task automatic check_grant_order(input mid_t got, input mid_t exp, input string what);
        if (got !== exp) begin
            stop_failed($sformatf("CHECK FAILED at %0t: %s, served master %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_failed($sformatf("CHECK FAILED at %0t: %s, ack after %0d edges, expected %0d",
                $time, what, got, exp));
        end
    endtask

    // Random transfer, unknown words get a full write first
    task automatic make_xfer(output wb_req_t r);
        int unsigned word;
        word  = $urandom_range(WORDS - 1, 0);
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.adr = `WB_ADDR_WIDTH'(word * SELW);
        r.we  = 1'($urandom);
        r.sel = SELW'($urandom);
        r.dat = $urandom;
        if (!written[IDXW'(word)]) begin
            r.we  = 1'b1;
            r.sel = '1;
        end
    endtask

    // Applied at the ack edge, in ack order
    task automatic finish_xfer(input mid_t m, input wb_req_t r);
        logic [IDXW-1:0]           idx;
        logic [`WB_DATA_WIDTH-1:0] word;
        wb_rsp_t                   exp;
        idx = IDXW'((r.adr / SELW) % WORDS);   // Byte address to word, wraps
        if (r.we) begin
            word = ref_mem[idx];
            for (int b = 0; b < SELW; b++) begin
                if (r.sel[b]) begin
                    word[8*b +: 8] = r.dat[8*b +: 8];    // Merge lane
                end
            end
            ref_mem[idx] <= word;
            written[idx] <= 1'b1;
        end else begin
            exp.dat = ref_mem[idx];
            exp.ack = 1'b1;
            check_rsp(m_rsp[m], exp, $sformatf("read of word %0d by master %0d", idx, m));
        end
    endtask

    task automatic wait_ack(input mid_t m, output int edges);
        edges = 0;
        forever begin
            @(posedge clk);
            edges = edges + 1;
            if (m_rsp[m].ack) begin
                break;
            end
            if (edges >= ACK_TIMEOUT) begin
                stop_failed($sformatf("Master %0d got no ack within %0d cycles at time %0t",
                    m, ACK_TIMEOUT, $time));
            end
        end
    endtask

    // Called on a rising edge, drives on that edge
    task automatic run_cycle(input mid_t m, input int n_xfer, output int first_wait);
        wb_req_t r;
        int      waited;
        first_wait = 0;
        for (int t = 0; t < n_xfer; t++) begin
            make_xfer(r);
            m_req[m] <= r;                      // Hold until ack
            wait_ack(m, waited);
            if (t == 0) begin
                first_wait = waited;
            end
            finish_xfer(m, r);
        end
        m_req[m] <= '0;                         // Drop cyc on the last ack edge
    endtask

    task automatic tie_round(input mid_t first, input string what);
        int w0;
        int w1;
        repeat (2) @(posedge clk);
        fork
            run_cycle(1'b0, 1, w0);
            run_cycle(1'b1, 1, w1);
        join
        check_grant_order((w0 < w1) ? 1'b0 : 1'b1, first, what);
    endtask

    task automatic idle_round(input mid_t m);
        int w;
        repeat (2) @(posedge clk);
        run_cycle(m, 1, w);
        check_latency(w, IDLE_ACK_EDGES, $sformatf("idle latency of master %0d", m));
    endtask

    task automatic master_loop(input mid_t m);
        int done;
        int n;
        int w;
        done = 0;
        while (done < XFERS) begin
            n = $urandom_range(4, 1);
            if (n > XFERS - done) begin
                n = XFERS - done;
            end
            repeat ($urandom_range(3, 0)) @(posedge clk);   // Idle gap
            @(posedge clk);
            run_cycle(m, n, w);
            done = done + n;
        end
    endtask

    // Ack rules and bus ownership, sampled on every edge
    always @(posedge clk) begin : bus_monitor
        wb_rsp_t quiet;
        mid_t    m;
        logic    any_ack;
        quiet   = '0;
        any_ack = 1'b0;
        for (int i = 0; i < 2; i++) begin
            m = mid_t'(i);
            if (reset_seen && (reset_i || prev_ack || !(m_req[m].cyc && m_req[m].stb))) begin
                check_rsp(m_rsp[m], quiet, $sformatf("unexpected ack to master %0d", m));
            end
            if (m_rsp[m].ack) begin
                if (owner_valid) begin
                    check_grant_order(m, owner, "ack inside another bus cycle");
                end
                owner       = m;
                owner_valid = 1'b1;
                any_ack     = 1'b1;
            end
        end
        if (owner_valid && !m_req[owner].cyc) begin
            owner_valid = 1'b0;                 // Owner ended its cycle
        end
        prev_ack   = any_ack;
        reset_seen = reset_seen | reset_i;      // Ack register defined after a reset edge
    end

    initial begin : main
        void'($urandom(SEED));
        reset_i  <= 1'b1;
        m_req[0] <= '0;
        m_req[1] <= '0;
        for (int i = 0; i < WORDS; i++) begin
            written[i] <= 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        tie_round(1'b0, "first tie after reset");
        idle_round(1'b1);
        idle_round(1'b0);                       // Master 0 served last
        tie_round(1'b1, "tie after master 0 served");

        fork
            master_loop(1'b0);
            master_loop(1'b1);
        join
        repeat (2) @(posedge clk);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
logic/wb_pkg.sv
logic/arb_pkg.sv
logic/arbiter.sv
logic/wb_arbiter_2.sv
logic/wb_ram.sv
logic/wb_arb_ram_top.sv
tests/tb_wb_arb_ram.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_wb_arb_ram
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
